// File: src/ahb_lite_pkg.sv
package ahb_lite_pkg;

    typedef enum logic [1:0]
    {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [2:0]
    {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_t;

    // Address-phase signals only; HWDATA follows a cycle later.
    typedef struct packed
    {
        logic [31:0] haddr;
        htrans_t     htrans;
        hsize_t      hsize;
        logic        hwrite;
    } ahb_req_t;

    typedef struct packed
    {
        logic [31:0] hrdata;
        logic        hready;
        logic        hresp;
    } ahb_rsp_t;

    typedef logic [3:0] region_t;

    localparam region_t RAM_REGION  = 4'd0;
    localparam region_t GPIO_REGION = 4'd1;

    localparam logic HRESP_OKAY  = 1'b0;
    localparam logic HRESP_ERROR = 1'b1;

    // IDLE and BUSY carry no data phase.
    function automatic logic is_transfer(htrans_t htrans);
        return (htrans == NONSEQ) || (htrans == SEQ);
    endfunction

    function automatic region_t region_of(logic [31:0] haddr);
        return haddr[31:28];
    endfunction

endpackage

// File: src/ahb_lite_decoder.sv
module ahb_lite_decoder
#(
    parameter int RAM_ADDR_WIDTH = 6
)
(
    input  logic                          HCLK,
    input  logic                          reset,
    input  ahb_lite_pkg::ahb_req_t        req,
    input  logic                          hsel,
    input  logic                          hready_in,
    output logic                          hready_out,
    output logic [RAM_ADDR_WIDTH - 1:0]   read_addr,
    output logic [RAM_ADDR_WIDTH - 1:0]   write_addr,
    output logic [3:0]                    write_mask
);
    import ahb_lite_pkg::*;

    logic                        accept;
    logic [RAM_ADDR_WIDTH - 1:0] req_word;
    logic [3:0]                  lane_mask;
    logic [RAM_ADDR_WIDTH - 1:0] addr_q;
    logic [3:0]                  write_mask_q;
    logic                        stall_q;

    assign accept   = hsel && hready_in && is_transfer(req.htrans);
    assign req_word = req.haddr[RAM_ADDR_WIDTH + 1:2];

    always_comb
    begin
        case (req.hsize)
            BYTE:    lane_mask = 4'b0001 << req.haddr[1:0];
            HALF:    lane_mask = req.haddr[1] ? 4'b1100 : 4'b0011;
            default: lane_mask = 4'b1111;
        endcase
    end

    // Holds the word of the transfer now in its data phase.
    always_ff @(posedge HCLK)
    begin
        if (accept)
            addr_q <= req_word;
    end

    always_ff @(posedge HCLK)
    begin
        if (reset)
        begin
            write_mask_q <= 4'b0;
            stall_q      <= 1'b0;
        end
        else
        begin
            // A read of the word being written this cycle would see the old contents.
            stall_q <= accept && !req.hwrite && (write_mask_q != 4'b0)
                       && (req_word == addr_q);
            if (hready_in)
                write_mask_q <= (accept && req.hwrite) ? lane_mask : 4'b0;
        end
    end

    assign hready_out = !stall_q;
    assign read_addr  = stall_q ? addr_q : req_word; // Re-issue the stalled read.
    assign write_addr = addr_q;
    assign write_mask = hready_in ? write_mask_q : 4'b0; // Commit as the data phase ends.

    assert property (@(posedge HCLK) disable iff (reset)
        (write_mask != 4'b0) |-> $past(accept && req.hwrite));

    assert property (@(posedge HCLK) disable iff (reset)
        !hready_out |=> hready_out);

endmodule

// File: src/dual_port_ram.sv
module dual_port_ram
#(
    parameter int RAM_ADDR_WIDTH = 6
)
(
    input  logic                        HCLK,
    input  logic [RAM_ADDR_WIDTH - 1:0] read_addr,
    input  logic [RAM_ADDR_WIDTH - 1:0] write_addr,
    input  logic [31:0]                 write_data,
    input  logic [3:0]                  write_mask,
    output logic [31:0]                 read_data
);
    logic [31:0] mem [2 ** RAM_ADDR_WIDTH];

    always_ff @(posedge HCLK)
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (write_mask[i])
                mem[write_addr][i * 8 +: 8] <= write_data[i * 8 +: 8];
        end
    end

    // Same-word read and write on one edge returns the old word.
    always_ff @(posedge HCLK)
    begin
        read_data <= mem[read_addr];
    end

endmodule

// File: src/ahb_ram_slave.sv
module ahb_ram_slave
#(
    parameter int RAM_ADDR_WIDTH = 6
)
(
    input  logic                   HCLK,
    input  logic                   reset,
    input  ahb_lite_pkg::ahb_req_t req,
    input  logic                   hsel,
    input  logic                   hready_in,
    input  logic [31:0]            hwdata,
    output ahb_lite_pkg::ahb_rsp_t rsp
);
    import ahb_lite_pkg::*;

    logic [RAM_ADDR_WIDTH - 1:0] read_addr;
    logic [RAM_ADDR_WIDTH - 1:0] write_addr;
    logic [3:0]                  write_mask;
    logic [31:0]                 read_data;
    logic                        ready;

    ahb_lite_decoder
    #(
        .RAM_ADDR_WIDTH ( RAM_ADDR_WIDTH )
    )
    decoder
    (
        .HCLK       ( HCLK       ),
        .reset      ( reset      ),
        .req        ( req        ),
        .hsel       ( hsel       ),
        .hready_in  ( hready_in  ),
        .hready_out ( ready      ),
        .read_addr  ( read_addr  ),
        .write_addr ( write_addr ),
        .write_mask ( write_mask )
    );

    dual_port_ram
    #(
        .RAM_ADDR_WIDTH ( RAM_ADDR_WIDTH )
    )
    ram
    (
        .HCLK       ( HCLK       ),
        .read_addr  ( read_addr  ),
        .write_addr ( write_addr ),
        .write_data ( hwdata     ),
        .write_mask ( write_mask ),
        .read_data  ( read_data  )
    );

    // The RAM never signals an error.
    assign rsp = '{hrdata: read_data, hready: ready, hresp: HRESP_OKAY};

endmodule

// File: src/ahb_gpio_slave.sv
module ahb_gpio_slave
#(
    parameter int GPIO_WIDTH = 16
)
(
    input  logic                    HCLK,
    input  logic                    reset,
    input  ahb_lite_pkg::ahb_req_t  req,
    input  logic                    hsel,
    input  logic                    hready_in,
    input  logic [31:0]             hwdata,
    input  logic [GPIO_WIDTH - 1:0] gpio_in,
    output logic [GPIO_WIDTH - 1:0] gpio_out,
    output ahb_lite_pkg::ahb_rsp_t  rsp
);
    import ahb_lite_pkg::*;

    logic                    accept;
    logic                    write_out_q;
    logic                    read_in_q;
    logic [GPIO_WIDTH - 1:0] in_meta_q;
    logic [GPIO_WIDTH - 1:0] in_sync_q;
    logic [31:0]             read_data;

    assign accept = hsel && hready_in && is_transfer(req.htrans);

    // Address bit 2 picks the register. Offset 0 is gpio_out and offset 4 is gpio_in.
    always_ff @(posedge HCLK)
    begin
        if (reset)
        begin
            write_out_q <= 1'b0;
            read_in_q   <= 1'b0;
        end
        else if (hready_in)
        begin
            write_out_q <= accept && req.hwrite && !req.haddr[2];
            read_in_q   <= accept && !req.hwrite && req.haddr[2];
        end
    end

    always_ff @(posedge HCLK)
    begin
        if (reset)
            gpio_out <= '0;
        else if (hready_in && write_out_q)
            gpio_out <= hwdata[GPIO_WIDTH - 1:0]; // Data phase ends here.
    end

    // Two flops bring the pins into the HCLK domain.
    always_ff @(posedge HCLK)
    begin
        in_meta_q <= gpio_in;
        in_sync_q <= in_meta_q;
    end

    assign read_data = read_in_q ? 32'(in_sync_q) : 32'(gpio_out);

    assign rsp = '{hrdata: read_data, hready: 1'b1, hresp: HRESP_OKAY};

endmodule

// File: src/ahb_response_mux.sv
module ahb_response_mux
(
    input  logic                   HCLK,
    input  logic                   reset,
    input  ahb_lite_pkg::ahb_req_t req,
    input  ahb_lite_pkg::ahb_rsp_t ram_rsp,
    input  ahb_lite_pkg::ahb_rsp_t gpio_rsp,
    output logic                   hsel_ram,
    output logic                   hsel_gpio,
    output logic [31:0]            hrdata,
    output logic                   hready,
    output logic                   hresp
);
    import ahb_lite_pkg::*;

    typedef enum logic [1:0] {OKAY_PHASE, ERR_FIRST, ERR_SECOND} err_state_t;

    err_state_t state_q;
    err_state_t state_next;
    region_t    region;
    region_t    owner_q;
    logic       accept;
    logic       active_q;
    ahb_rsp_t   rsp;

    assign region    = region_of(req.haddr);
    assign hsel_ram  = (region == RAM_REGION);
    assign hsel_gpio = (region == GPIO_REGION);
    assign accept    = hready && is_transfer(req.htrans);

    always_comb
    begin
        state_next = OKAY_PHASE;
        if (state_q == ERR_FIRST)
            state_next = ERR_SECOND;
        else if (accept && !hsel_ram && !hsel_gpio)
            state_next = ERR_FIRST; // Nothing lives at this address.
    end

    always_ff @(posedge HCLK)
    begin
        if (reset)
        begin
            state_q  <= OKAY_PHASE;
            active_q <= 1'b0;
        end
        else
        begin
            state_q <= state_next;
            if (hready)
                active_q <= accept && (hsel_ram || hsel_gpio);
        end
    end

    always_ff @(posedge HCLK)
    begin
        if (accept)
            owner_q <= region;
    end

    always_comb
    begin
        rsp = '{hrdata: 32'b0, hready: 1'b1, hresp: HRESP_OKAY};
        case (state_q)
            ERR_FIRST:  rsp = '{hrdata: 32'b0, hready: 1'b0, hresp: HRESP_ERROR};
            ERR_SECOND: rsp = '{hrdata: 32'b0, hready: 1'b1, hresp: HRESP_ERROR};
            default:
            begin
                if (active_q && (owner_q == RAM_REGION))
                    rsp = ram_rsp;
                else if (active_q && (owner_q == GPIO_REGION))
                    rsp = gpio_rsp;
            end
        endcase
    end

    assign hrdata = rsp.hrdata;
    assign hready = rsp.hready;
    assign hresp  = rsp.hresp;

    assert property (@(posedge HCLK) disable iff (reset) active_q |-> (hresp == HRESP_OKAY));

endmodule

// File: src/ahb_lite_matrix.sv
module ahb_lite_matrix
#(
    parameter int RAM_ADDR_WIDTH = 6,
    parameter int GPIO_WIDTH     = 16
)
(
    input  logic                    HCLK,
    input  logic                    reset,
    input  ahb_lite_pkg::ahb_req_t  hreq,
    input  logic [31:0]             hwdata,
    output logic [31:0]             hrdata,
    output logic                    hready,
    output logic                    hresp,
    input  logic [GPIO_WIDTH - 1:0] gpio_in,
    output logic [GPIO_WIDTH - 1:0] gpio_out
);
    import ahb_lite_pkg::*;

    ahb_rsp_t ram_rsp;
    ahb_rsp_t gpio_rsp;
    logic     hsel_ram;
    logic     hsel_gpio;

    // Both slaves watch the muxed hready to know when an address phase is taken.
    ahb_ram_slave
    #(
        .RAM_ADDR_WIDTH ( RAM_ADDR_WIDTH )
    )
    ram_slave
    (
        .HCLK      ( HCLK     ),
        .reset     ( reset    ),
        .req       ( hreq     ),
        .hsel      ( hsel_ram ),
        .hready_in ( hready   ),
        .hwdata    ( hwdata   ),
        .rsp       ( ram_rsp  )
    );

    ahb_gpio_slave
    #(
        .GPIO_WIDTH ( GPIO_WIDTH )
    )
    gpio_slave
    (
        .HCLK      ( HCLK      ),
        .reset     ( reset     ),
        .req       ( hreq      ),
        .hsel      ( hsel_gpio ),
        .hready_in ( hready    ),
        .hwdata    ( hwdata    ),
        .gpio_in   ( gpio_in   ),
        .gpio_out  ( gpio_out  ),
        .rsp       ( gpio_rsp  )
    );

    ahb_response_mux response_mux
    (
        .HCLK      ( HCLK      ),
        .reset     ( reset     ),
        .req       ( hreq      ),
        .ram_rsp   ( ram_rsp   ),
        .gpio_rsp  ( gpio_rsp  ),
        .hsel_ram  ( hsel_ram  ),
        .hsel_gpio ( hsel_gpio ),
        .hrdata    ( hrdata    ),
        .hready    ( hready    ),
        .hresp     ( hresp     )
    );

endmodule

// File: sim/tb_ahb_lite_matrix.sv
module tb_ahb_lite_matrix;
    import ahb_lite_pkg::*;

    localparam int RAM_ADDR_WIDTH = 6;
    localparam int GPIO_WIDTH     = 16;
    localparam int RAM_WORDS      = 2 ** RAM_ADDR_WIDTH;
    localparam int CLK_PERIOD     = 100;
    // Fill and readback, lane sweep, stall test, GPIO, error test, reset.
    localparam int TRANSFERS      = 2 * RAM_WORDS + 12 + 3 + 5 + 2 + 1;
    localparam int TIMEOUT_CYCLES = 40 * TRANSFERS;

    localparam logic [31:0] GPIO_OUT_ADDR = 32'h1000_0000;
    localparam logic [31:0] GPIO_IN_ADDR  = 32'h1000_0004;
    localparam logic [31:0] UNMAPPED_ADDR = 32'h3000_0010;
    localparam ahb_req_t    IDLE_REQ      = '{haddr: 32'b0, htrans: IDLE, hsize: WORD, hwrite: 1'b0};

    logic                    HCLK;
    logic                    reset;
    ahb_req_t                hreq;
    logic [31:0]             hwdata;
    logic [31:0]             hrdata;
    logic                    hready;
    logic                    hresp;
    logic [GPIO_WIDTH - 1:0] gpio_in;
    logic [GPIO_WIDTH - 1:0] gpio_out;

    logic [31:0] model [RAM_WORDS];
    integer      seed;
    int          checks;
    int          errors;
    int          wait_cycles;
    logic        last_hresp;

    ahb_lite_matrix
    #(
        .RAM_ADDR_WIDTH ( RAM_ADDR_WIDTH ),
        .GPIO_WIDTH     ( GPIO_WIDTH     )
    )
    DUT
    (
        .HCLK     ( HCLK     ),
        .reset    ( reset    ),
        .hreq     ( hreq     ),
        .hwdata   ( hwdata   ),
        .hrdata   ( hrdata   ),
        .hready   ( hready   ),
        .hresp    ( hresp    ),
        .gpio_in  ( gpio_in  ),
        .gpio_out ( gpio_out )
    );

    initial
    begin
        HCLK = 1'b0;
        forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
    end

    initial
    begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the bus stopped answering within %0d cycles.", TIMEOUT_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic expect_true(logic cond, string what);
        checks++;
        assert (cond === 1'b1)
        else
        begin
            errors++;
            $display("Protocol error: %s", what);
        end
    endtask

    function automatic logic [31:0] ram_addr(int word, int offset);
        return 32'(word * 4 + offset);
    endfunction

    // Byte lanes touched by a write of this size at this offset.
    function automatic logic [3:0] lanes_for(hsize_t size, int offset);
        logic [3:0] lanes;
        int         bytes;
        bytes = 1 << size;
        lanes = 4'b0;
        for (int lane = 0; lane < 4; lane++)
        begin
            if ((lane >= offset) && (lane < offset + bytes))
                lanes[lane] = 1'b1;
        end
        return lanes;
    endfunction

    function automatic ahb_req_t make_req(logic [31:0] addr, hsize_t size, logic write);
        return '{haddr: addr, htrans: NONSEQ, hsize: size, hwrite: write};
    endfunction

    task automatic issue_address(ahb_req_t req);
        @(negedge HCLK);
        hreq = req;
        while (hready !== 1'b1)
            @(negedge HCLK);
    endtask

    task automatic finish_data_phase();
        wait_cycles = 0;
        while (hready !== 1'b1)
        begin
            wait_cycles++;
            @(negedge HCLK);
        end
        last_hresp = hresp;
    endtask

    task automatic write_transfer(logic [31:0] addr, hsize_t size, logic [31:0] data);
        issue_address(make_req(addr, size, 1'b1));
        @(negedge HCLK);
        hreq   = IDLE_REQ;
        hwdata = data;
        finish_data_phase();
    endtask

    task automatic read_transfer(logic [31:0] addr, output logic [31:0] data);
        issue_address(make_req(addr, WORD, 1'b0));
        @(negedge HCLK);
        hreq = IDLE_REQ;
        finish_data_phase();
        data = hrdata;
    endtask

    task automatic inspect_reset_state();
        check_value("hready", 32'd1, 32'(hready));
        check_value("hresp", 32'd0, 32'(hresp));
        check_value("gpio_out", 32'd0, 32'(gpio_out));
    endtask

    task automatic fill_and_verify_ram();
        logic [31:0] data;
        for (int w = 0; w < RAM_WORDS; w++)
        begin
            data     = $random(seed);
            model[w] = data;
            write_transfer(ram_addr(w, 0), WORD, data);
        end
        for (int w = 0; w < RAM_WORDS; w++)
        begin
            read_transfer(ram_addr(w, 0), data);
            check_value("hrdata", model[w], data);
        end
    endtask

    task automatic sweep_byte_lanes();
        logic [31:0] data;
        logic [3:0]  mask;
        hsize_t      size;
        int          offset;
        int          word;
        for (int n = 0; n < 6; n++)
        begin
            size   = (n < 4) ? BYTE : HALF;
            offset = (n < 4) ? n : (n - 4) * 2;
            word   = {$random(seed)} % RAM_WORDS;
            data   = $random(seed);
            mask   = lanes_for(size, offset);
            write_transfer(ram_addr(word, offset), size, data);
            for (int lane = 0; lane < 4; lane++)
            begin
                if (mask[lane])
                    model[word][lane * 8 +: 8] = data[lane * 8 +: 8];
            end
            read_transfer(ram_addr(word, 0), data);
            check_value("hrdata", model[word], data);
        end
    endtask

    task automatic read_after_write();
        logic [31:0] data;
        int          word;
        word = {$random(seed)} % RAM_WORDS;
        data = $random(seed);
        issue_address(make_req(ram_addr(word, 0), WORD, 1'b1));
        @(negedge HCLK);
        check_value("hready", 32'd1, 32'(hready));
        hwdata      = data; // Write data phase overlaps the read address phase.
        hreq        = make_req(ram_addr(word, 0), WORD, 1'b0);
        model[word] = data;
        @(negedge HCLK);
        hreq = IDLE_REQ;
        finish_data_phase();
        expect_true(wait_cycles == 1, "read after write did not stall for exactly one cycle");
        check_value("hrdata", model[word], hrdata);
        read_transfer(ram_addr(word, 0), data);
        check_value("hrdata", model[word], data);
    endtask

    task automatic exercise_gpio();
        logic [31:0] data;
        logic [31:0] value;
        logic [31:0] pins;
        value = $random(seed);
        pins  = $random(seed);
        write_transfer(GPIO_OUT_ADDR, WORD, value);
        @(negedge HCLK);
        check_value("gpio_out", 32'(value[GPIO_WIDTH - 1:0]), 32'(gpio_out));
        read_transfer(GPIO_OUT_ADDR, data);
        check_value("hrdata", 32'(value[GPIO_WIDTH - 1:0]), data);
        gpio_in = pins[GPIO_WIDTH - 1:0];
        repeat (3) @(negedge HCLK); // Synchronizer depth plus one.
        read_transfer(GPIO_IN_ADDR, data);
        check_value("hrdata", 32'(pins[GPIO_WIDTH - 1:0]), data);
        write_transfer(GPIO_IN_ADDR, WORD, ~value);
        @(negedge HCLK);
        check_value("gpio_out", 32'(value[GPIO_WIDTH - 1:0]), 32'(gpio_out));
        read_transfer(GPIO_IN_ADDR, data);
        check_value("hrdata", 32'(pins[GPIO_WIDTH - 1:0]), data);
    endtask

    task automatic probe_unmapped();
        logic [31:0] data;
        issue_address(make_req(UNMAPPED_ADDR, WORD, 1'b0));
        @(negedge HCLK);
        hreq = IDLE_REQ;
        check_value("hready", 32'd0, 32'(hready));
        check_value("hresp", 32'd1, 32'(hresp));
        @(negedge HCLK);
        check_value("hready", 32'd1, 32'(hready));
        check_value("hresp", 32'd1, 32'(hresp));
        read_transfer(ram_addr(5, 0), data);
        check_value("hrdata", model[5], data);
        expect_true(last_hresp == 1'b0, "RAM read after the error response still flagged an error");
    endtask

    initial
    begin
        seed        = 32'hc3a5_5f95;
        checks      = 0;
        errors      = 0;
        wait_cycles = 0;
        last_hresp  = 1'b0;
        reset       = 1'b1;
        hreq        = IDLE_REQ;
        hwdata      = 32'b0;
        gpio_in     = '0;
        repeat (3) @(posedge HCLK);
        @(negedge HCLK);
        reset = 1'b0;
        inspect_reset_state();
        fill_and_verify_ram();
        sweep_byte_lanes();
        read_after_write();
        exercise_gpio();
        probe_unmapped();
        @(negedge HCLK);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: sources.f
src/ahb_lite_pkg.sv
src/ahb_lite_decoder.sv
src/dual_port_ram.sv
src/ahb_ram_slave.sv
src/ahb_gpio_slave.sv
src/ahb_response_mux.sv
src/ahb_lite_matrix.sv
sim/tb_ahb_lite_matrix.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    -f sources.f \
    --top-module tb_ahb_lite_matrix \
    -Mdir obj_dir \
    -o tb_ahb_lite_matrix

./obj_dir/tb_ahb_lite_matrix | tee "$LOG"

if grep -q "^TEST PASSED$" "$LOG"; then
    echo "Simulation passed."
else
    echo "Simulation failed, see $LOG."
    exit 1
fi
